/* flist.f */
+incdir+testbench
hw/vtb_pkg.sv
hw/vid_pos_track.sv
hw/ovl_bitmap_gen.sv
hw/ovl_mixer.sv
hw/vtb_ovl_top.sv
testbench/tb_vtb_ovl.sv

/* hw/ovl_bitmap_gen.sv */
module ovl_bitmap_gen
(
    input  logic               CLK_IN,
    input  logic               rst_n,
    input  vtb_pkg::ovl_img_e  img_sel,
    input  vtb_pkg::ovl_pos_t  pos,
    input  vtb_pkg::vid_beat_t vid_in,
    output vtb_pkg::vid_beat_t vid_out,
    output logic               hit
);
    import vtb_pkg::*;

    vid_beat_t vid_q;       // Delayed beat
    logic      hit_q;
    logic      grid_hit;
    logic      chk_hit;
    logic      img_hit;     // Selected image at this cell

    // Image formulas over the cell address
    always_comb
    begin
        // Grid, any low nibble of zero
        grid_hit = (pos.col[GRID_BITS-1:0] == '0) ||
                   (pos.row[GRID_BITS-1:0] == '0);

        // Checker, alternate every 16 cells in both directions
        chk_hit  = pos.col[CHK_BIT] ^ pos.row[CHK_BIT];

        case (img_sel)
            IMG_CHECKER : img_hit = chk_hit;
            default     : img_hit = grid_hit;
        endcase
    end

    // Hit bit, unmasked
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            hit_q <= 1'b0;
        end
        else
        begin
            hit_q <= img_hit;   // Mixer applies de
        end
    end

    // Beat delay to stay aligned with hit
    always_ff @(posedge CLK_IN)
    begin
        vid_q <= vid_in;
        if (!rst_n)
        begin
            vid_q.vs <= 1'b0;
            vid_q.hs <= 1'b0;
            vid_q.de <= 1'b0;
        end
    end

    assign vid_out = vid_q;
    assign hit     = hit_q;

endmodule

/* hw/ovl_mixer.sv */
module ovl_mixer
(
    input  logic               CLK_IN,
    input  logic               rst_n,
    input  logic               run,
    input  vtb_pkg::vid_beat_t vid_in,
    input  logic               hit,
    output vtb_pkg::vid_beat_t vid_out
);
    import vtb_pkg::*;

    vid_beat_t vid_q;       // Output register
    logic      sub_en;      // Replace this beat

    always_comb
    begin
        // Only active pixels are touched
        sub_en = run && hit && vid_in.de;
    end

    always_ff @(posedge CLK_IN)
    begin
        // Default pass through
        vid_q <= vid_in;

        // Overlay
        if (sub_en)
        begin
            vid_q.r <= {PPC{OVL_GREY}};     // Grey for every pixel of a beat
            vid_q.g <= {PPC{OVL_GREY}};
            vid_q.b <= {PPC{OVL_GREY}};
        end

        // Sync and enable low out of reset
        if (!rst_n)
        begin
            vid_q.vs <= 1'b0;
            vid_q.hs <= 1'b0;
            vid_q.de <= 1'b0;
        end
    end

    assign vid_out = vid_q;

    // Reset of all three stages must leave a defined enable at the output
    a_de_known : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        !$isunknown(vid_out.de))
        else $error("output de unknown after reset");

endmodule

/* hw/vid_pos_track.sv */
module vid_pos_track
(
    input  logic               CLK_IN,
    input  logic               rst_n,
    input  vtb_pkg::vid_beat_t vid_in,
    output vtb_pkg::vid_beat_t vid_out,
    output vtb_pkg::ovl_pos_t  pos
);
    import vtb_pkg::*;

    vid_beat_t           vid_q;     // Stage register
    ovl_pos_t            pos_q;     // Cell of the registered beat
    logic [CNT_BITS-1:0] pix_cnt;   // Beats since last hs
    logic [CNT_BITS-1:0] lin_cnt;   // Active lines since last vs
    logic [CNT_BITS-1:0] pix_cur;   // Beat count seen by the current beat
    logic [CNT_BITS-1:0] lin_cur;   // Line count seen by the current beat
    logic [CNT_BITS-1:0] col_cnt;
    logic [CNT_BITS-1:0] row_cnt;
    logic                de_fe;     // End of active line

    // Previous de is simply the registered beat
    always_comb
    begin
        de_fe   = vid_q.de && !vid_in.de;

        // Sync clears apply to the beat that carries them
        pix_cur = vid_in.hs ? '0 : pix_cnt;
        lin_cur = vid_in.vs ? '0 : lin_cnt;

        col_cnt = pix_cur >> COL_SHIFT;
        row_cnt = lin_cur >> ROW_SHIFT;
    end

    // Beat counter
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            pix_cnt <= '0;
        end
        else if (vid_in.hs)
        begin
            pix_cnt <= '0;                  // New line
        end
        else if (vid_in.de)
        begin
            pix_cnt <= pix_cnt + 1'b1;      // Active beat
        end
    end

    // Line counter
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            lin_cnt <= '0;
        end
        else if (vid_in.vs)
        begin
            lin_cnt <= '0;                  // New frame
        end
        else if (de_fe)
        begin
            lin_cnt <= lin_cnt + 1'b1;
        end
    end

    // Beat register, only sync and enable are reset
    always_ff @(posedge CLK_IN)
    begin
        vid_q <= vid_in;
        if (!rst_n)
        begin
            vid_q.vs <= 1'b0;
            vid_q.hs <= 1'b0;
            vid_q.de <= 1'b0;
        end
    end

    // Position travels with the beat, count before the increment
    always_ff @(posedge CLK_IN)
    begin
        pos_q.col <= col_cnt[CELL_BITS-1:0];   // Truncated cell index
        pos_q.row <= row_cnt[CELL_BITS-1:0];
    end

    assign vid_out = vid_q;
    assign pos     = pos_q;

    // Sync and enable are exclusive on the input stream
    a_hs_de_excl : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        !(vid_in.hs && vid_in.de))
        else $error("hs and de high on the same beat");

    // A line longer than the counter would alias columns
    a_pix_no_wrap : assert property (@(posedge CLK_IN) disable iff (!rst_n)
        vid_in.de |-> (pix_cnt != '1))
        else $error("beat counter wrapped within a line");

endmodule

/* hw/vtb_ovl_top.sv */
module vtb_ovl_top
(
    input  logic               CLK_IN,
    input  logic               rst_n,
    input  logic               run,
    input  vtb_pkg::ovl_img_e  img_sel,
    input  vtb_pkg::vid_beat_t vid_in,
    output vtb_pkg::vid_beat_t vid_out
);
    import vtb_pkg::*;

    vid_beat_t trk_vid;     // Stage 1 beat
    ovl_pos_t  trk_pos;     // Stage 1 cell position
    vid_beat_t bmp_vid;     // Stage 2 beat
    logic      bmp_hit;     // Stage 2 overlay bit

    // Stage 1, position
    vid_pos_track pos_track_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .vid_in  (vid_in),
        .vid_out (trk_vid),
        .pos     (trk_pos)
    );

    // Stage 2, image lookup
    ovl_bitmap_gen bitmap_gen_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .img_sel (img_sel),
        .pos     (trk_pos),
        .vid_in  (trk_vid),
        .vid_out (bmp_vid),
        .hit     (bmp_hit)
    );

    // Stage 3, grey substitution
    ovl_mixer mixer_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .run     (run),
        .vid_in  (bmp_vid),
        .hit     (bmp_hit),
        .vid_out (vid_out)
    );

endmodule

/* hw/vtb_pkg.sv */
package vtb_pkg;

    // Stream format
    localparam int PPC      = 2;    // Pixels per beat
    localparam int BPC      = 8;    // Bits per component
    localparam int CNT_BITS = 16;   // Beat and line counter width

    // Bitmap cell addressing
    localparam int CELL_BITS = 9;   // Row and column index width
    localparam int COL_SHIFT = (PPC == 4) ? 0 : 1;  // Two beats per column at 2 ppc
    localparam int ROW_SHIFT = 2;   // Four lines per row

    // Image formula constants
    localparam int GRID_BITS = 4;   // Grid line every 16 cells
    localparam int CHK_BIT   = 4;   // Checker square of 16 cells

    // Overlay colour, same value on R, G and B
    localparam logic [BPC-1:0] OVL_GREY = BPC'(180);

    // Colour field width of one beat
    localparam int COMP_BITS = PPC * BPC;

    // One beat of video, 51 bits at 2 ppc / 8 bpc
    typedef struct packed
    {
        logic                 vs;   // Vertical sync
        logic                 hs;   // Horizontal sync
        logic                 de;   // Data enable
        logic [COMP_BITS-1:0] r;    // Red, pixel 0 in the low bits
        logic [COMP_BITS-1:0] g;    // Green
        logic [COMP_BITS-1:0] b;    // Blue
    } vid_beat_t;

    // Coarse bitmap cell, 18 bits
    typedef struct packed
    {
        logic [CELL_BITS-1:0] row;
        logic [CELL_BITS-1:0] col;
    } ovl_pos_t;

    // Overlay image select
    typedef enum logic
    {
        IMG_GRID    = 1'b0,     // Grid lines on a 16 cell pitch
        IMG_CHECKER = 1'b1      // Checkerboard of 16 x 16 cells
    } ovl_img_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build the overlay pipeline testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 --top-module tb_vtb_ovl -f flist.f \
    && ./obj_dir/Vtb_vtb_ovl > "$LOG" 2>&1 \
    || { echo "Build or simulation run did not complete"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

grep -q "Verification failed" "$LOG" && { echo "Simulation FAIL"; exit 1; } \
    || { echo "Simulation PASS"; exit 0; }

/* testbench/tb_ovl_model.svh */
`ifndef TB_OVL_MODEL_SVH
`define TB_OVL_MODEL_SVH

// Reference model of the overlay pipeline, fed with every driven beat

localparam int PIPE_DEPTH = 3;      // Input to output latency in beats

logic [CNT_BITS-1:0] ref_pix;       // Active beats since hs
logic [CNT_BITS-1:0] ref_lin;       // Completed active lines since vs
logic                ref_prev_de;   // de of the previous beat
vid_beat_t           exp_q[$];      // Expected output, PIPE_DEPTH deep
int                  grey_beats;    // Beats the model turned grey

// Image rules over the cell address
function automatic logic cell_is_set(input ovl_img_e img,
                                     input logic [CELL_BITS-1:0] row,
                                     input logic [CELL_BITS-1:0] col);
    case (img)
        IMG_CHECKER : return col[4] != row[4];                   // 16 cell squares
        default     : return (col[3:0] == 4'd0) || (row[3:0] == 4'd0);
    endcase
endfunction

// Counters cleared, pipeline holds idle beats out of reset
task automatic reset_model();
    vid_beat_t idle_beat;
    idle_beat   = '0;
    ref_pix     = '0;
    ref_lin     = '0;
    ref_prev_de = 1'b0;
    grey_beats  = 0;
    exp_q.delete();
    repeat (PIPE_DEPTH) exp_q.push_back(idle_beat);
endtask

// Expected output for one input beat, then counter update
task automatic push_expected(input vid_beat_t beat, input logic run_v, input ovl_img_e img_v);
    logic [CNT_BITS-1:0]  pix_now;
    logic [CNT_BITS-1:0]  lin_now;
    logic [CNT_BITS-1:0]  col_full;
    logic [CNT_BITS-1:0]  row_full;
    vid_beat_t            exp_beat;
    pix_now  = beat.hs ? '0 : ref_pix;     // Sync clears count on its own beat
    lin_now  = beat.vs ? '0 : ref_lin;
    col_full = pix_now >> COL_SHIFT;
    row_full = lin_now >> ROW_SHIFT;
    exp_beat = beat;
    if (run_v && beat.de && cell_is_set(img_v, row_full[CELL_BITS-1:0],
                                        col_full[CELL_BITS-1:0]))
    begin
        for (int p = 0; p < PPC; p++)
        begin
            exp_beat.r[p*BPC +: BPC] = OVL_GREY;
            exp_beat.g[p*BPC +: BPC] = OVL_GREY;
            exp_beat.b[p*BPC +: BPC] = OVL_GREY;
        end
        grey_beats = grey_beats + 1;
    end
    exp_q.push_back(exp_beat);

    if (beat.hs)
        ref_pix = '0;
    else if (beat.de)
        ref_pix = ref_pix + 1'b1;
    if (beat.vs)
        ref_lin = '0;
    else if (ref_prev_de && !beat.de)
        ref_lin = ref_lin + 1'b1;           // End of an active line
    ref_prev_de = beat.de;
endtask

`endif

/* testbench/tb_vtb_ovl.sv */
module tb_vtb_ovl;
    timeunit 1ns;
    timeprecision 100ps;

    import vtb_pkg::*;

    // Frame geometry
    localparam int RST_CYCLES   = 16;
    localparam int FRAMES       = 8;
    localparam int VBLANK_LINES = 4;
    localparam int VSYNC_LINES  = 2;
    localparam int ACTIVE_LINES = 72;
    localparam int HS_BEATS     = 2;
    localparam int HBLANK_BEATS = 6;
    localparam int ACTIVE_BEATS = 48;
    localparam int LINE_BEATS   = HS_BEATS + HBLANK_BEATS + ACTIVE_BEATS;
    localparam int FRAME_LINES  = VBLANK_LINES + ACTIVE_LINES;
    localparam int CYCLE_LIMIT  = RST_CYCLES + FRAMES * FRAME_LINES * LINE_BEATS + 100;
    localparam int SEL_BEAT     = 10;   // Settings change inside the first vs line

    logic        CLK_IN;
    logic        rst_n;
    logic        run;
    ovl_img_e    img_sel;
    vid_beat_t   vid_in;
    vid_beat_t   vid_out;

    logic [31:0] rng_state;
    int          timing_errs;
    int          pixel_errs;
    int          beats_checked;
    int          cycle_cnt;

    `include "tb_ovl_model.svh"

    vtb_ovl_top dut_i
    (
        .CLK_IN  (CLK_IN),
        .rst_n   (rst_n),
        .run     (run),
        .img_sel (img_sel),
        .vid_in  (vid_in),
        .vid_out (vid_out)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever #5 CLK_IN = ~CLK_IN;   // 100 MHz
    end

    // Run limit from reset plus all frames
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge CLK_IN);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("ERROR: simulation timed out before all frames finished");
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Sync and enable fields
    task automatic check_timing(input vid_beat_t exp_beat, input vid_beat_t act_beat);
        if ({act_beat.vs, act_beat.hs, act_beat.de} !== {exp_beat.vs, exp_beat.hs, exp_beat.de})
        begin
            timing_errs = timing_errs + 1;
            $display("FAILED %0t: timing expected vs=%b hs=%b de=%b, got vs=%b hs=%b de=%b",
                     $time, exp_beat.vs, exp_beat.hs, exp_beat.de,
                     act_beat.vs, act_beat.hs, act_beat.de);
        end
    endtask

    // Colour fields
    task automatic check_pixels(input vid_beat_t exp_beat, input vid_beat_t act_beat);
        if ({act_beat.r, act_beat.g, act_beat.b} !== {exp_beat.r, exp_beat.g, exp_beat.b})
        begin
            pixel_errs = pixel_errs + 1;
            $display("FAILED %0t: pixels expected r=%h g=%h b=%h, got r=%h g=%h b=%h",
                     $time, exp_beat.r, exp_beat.g, exp_beat.b,
                     act_beat.r, act_beat.g, act_beat.b);
        end
    endtask

    // One clock: check the output, then drive a new beat
    task automatic send_beat(input logic vs, input logic hs, input logic de);
        vid_beat_t beat;
        vid_beat_t exp_beat;
        @(posedge CLK_IN);
        #1;
        exp_beat = exp_q.pop_front();
        check_timing(exp_beat, vid_out);
        check_pixels(exp_beat, vid_out);
        beats_checked = beats_checked + 1;

        beat.vs   = vs;
        beat.hs   = hs;
        beat.de   = de;
        rng_state = xorshift32(rng_state);
        beat.r    = rng_state[COMP_BITS-1:0];   // Random data on blank beats too
        rng_state = xorshift32(rng_state);
        beat.g    = rng_state[COMP_BITS-1:0];
        rng_state = xorshift32(rng_state);
        beat.b    = rng_state[COMP_BITS-1:0];
        vid_in    = beat;
        push_expected(beat, run, img_sel);
    endtask

    // First four frames walk all settings, the rest are random
    task automatic pick_overlay(input int frame);
        rng_state = xorshift32(rng_state);
        if (frame < 4)
        begin
            run     = frame[1];
            img_sel = ovl_img_e'(frame[0]);
        end
        else
        begin
            run     = rng_state[0];
            img_sel = ovl_img_e'(rng_state[1]);
        end
    endtask

    task automatic send_frame(input int frame);
        for (int line = 0; line < FRAME_LINES; line++)
        begin
            for (int b = 0; b < LINE_BEATS; b++)
            begin
                if (line == 0 && b == SEL_BEAT)
                    pick_overlay(frame);    // Only blank beats in flight here
                send_beat(line < VSYNC_LINES, b < HS_BEATS,
                          (line >= VBLANK_LINES) && (b >= HS_BEATS + HBLANK_BEATS));
            end
        end
    endtask

    initial
    begin
        rst_n         = 1'b0;
        run           = 1'b0;
        img_sel       = IMG_GRID;
        vid_in        = '0;
        rng_state     = 32'd28478;
        timing_errs   = 0;
        pixel_errs    = 0;
        beats_checked = 0;

        repeat (RST_CYCLES) @(posedge CLK_IN);
        #1;
        rst_n = 1'b1;
        reset_model();

        for (int f = 0; f < FRAMES; f++)
            send_frame(f);
        repeat (PIPE_DEPTH) send_beat(1'b0, 1'b0, 1'b0);   // Drain the pipeline

        $display("Checked %0d beats (%0d grey), %0d timing errors, %0d pixel errors",
                 beats_checked, grey_beats, timing_errs, pixel_errs);
        if (timing_errs == 0 && pixel_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule
